// ==== verilog/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;      // data and address word.
    typedef logic [4:0]  reg_addr_t;  // register index.
    typedef logic [2:0]  alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    // first fetch address unless the top level overrides it.
    localparam word_t RESET_PC_DEFAULT = 32'h0000_0004;

    // ############################
    // opcode and funct encodings.
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_SLT     = 6'h2a;

    // ############################
    typedef struct packed {
        reg_addr_t   rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } rtype_t;

    // low half is either r-type fields or the immediate.
    typedef union packed {
        rtype_t      r;
        logic [15:0] imm;
    } instr_low_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        instr_low_t  low;
    } instr_fields_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;     // second operand is the immediate.
        logic    reg_write;
        logic    dest_is_rt;
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jr;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  read;
        logic  write;
    } bus_req_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } cpu_state_e;

endpackage

`default_nettype wire

// ==== verilog/cpu_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    bus_done,
    input  mips_pkg::word_t         bus_rdata,
    input  logic                    halt_taken,
    input  mips_pkg::word_t         pc,
    input  mips_pkg::word_t         addr_src,    // alu result.
    input  mips_pkg::word_t         store_data,  // rt value for sw.
    output mips_pkg::bus_req_t      bus_req,
    output mips_pkg::instr_fields_t fields,
    output mips_pkg::ctrl_t         ctrl,
    output logic                    retire,
    output logic                    active
);

    import mips_pkg::*;

    cpu_state_e state;
    word_t      ir;
    logic       issued;  // request of this state already handed over.

    assign fields = instr_fields_t'(ir);
    assign retire = (state == WRITEBACK);
    assign active = (state != HALTED);

    // ############################
    // instruction decode.
    always_comb begin
        ctrl = '0;
        case (fields.opcode)
            OP_SPECIAL: begin
                ctrl.reg_write = 1'b1;
                case (fields.low.r.funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_JR: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.is_jr     = 1'b1;
                    end
                    default: ctrl.reg_write = 1'b0;  // unknown funct acts as nop.
                endcase
            end
            OP_ADDIU: begin
                ctrl.use_imm    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.dest_is_rt = 1'b1;
            end
            OP_LW: begin
                ctrl.use_imm    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.dest_is_rt = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
            end
            OP_SW: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ: ctrl.is_branch = 1'b1;
            OP_BNE: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = 1'b1;
            end
            default: ;
        endcase
    end

    // ############################
    // bus requests, one strobe per access.
    always_comb begin
        bus_req = '0;
        case (state)
            FETCH: begin
                bus_req.addr = pc;
                bus_req.read = !issued;
            end
            MEMORY: begin
                bus_req.addr  = addr_src;
                bus_req.wdata = store_data;
                bus_req.read  = ctrl.mem_read && !issued;
                bus_req.write = ctrl.mem_write && !issued;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= FETCH;
            issued <= 1'b0;
        end else begin
            if (bus_req.read || bus_req.write) issued <= 1'b1;
            if (bus_done) issued <= 1'b0;
            case (state)
                FETCH:     if (bus_done) state <= DECODE;
                DECODE:    state <= EXECUTE;
                EXECUTE:   state <= (ctrl.mem_read || ctrl.mem_write) ? MEMORY : WRITEBACK;
                MEMORY:    if (bus_done) state <= WRITEBACK;
                WRITEBACK: state <= halt_taken ? HALTED : FETCH;
                default:   state <= HALTED;  // stays until rst.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && bus_done) ir <= bus_rdata;  // instruction register.
    end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  mips_pkg::reg_addr_t wr_addr,
    input  logic                wr_en,
    input  mips_pkg::word_t     wr_data,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     v0
);

    import mips_pkg::*;

    word_t regs [1:31];  // no storage for r0.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];
    assign v0      = regs[2];

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  mips_pkg::instr_fields_t fields,
    input  mips_pkg::ctrl_t         ctrl,
    input  mips_pkg::word_t         rs_data,
    input  mips_pkg::word_t         rt_data,
    output mips_pkg::word_t         result
);

    import mips_pkg::*;

    word_t imm_ext;
    word_t op_b;

    // sign extended for addiu and the load/store offset.
    assign imm_ext = {{16{fields.low.imm[15]}}, fields.low.imm};
    assign op_b    = ctrl.use_imm ? imm_ext : rt_data;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: result = rs_data + op_b;
            ALU_SUB: result = rs_data - op_b;
            ALU_AND: result = rs_data & op_b;
            ALU_OR:  result = rs_data | op_b;
            ALU_SLT: result = {31'b0, $signed(rs_data) < $signed(op_b)};
            default: result = rs_data + op_b;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/pc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_unit #(
    parameter mips_pkg::word_t RESET_PC = mips_pkg::RESET_PC_DEFAULT
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            retire,
    input  mips_pkg::ctrl_t ctrl,
    input  logic [15:0]     imm,
    input  mips_pkg::word_t rs_data,
    input  mips_pkg::word_t rt_data,
    output mips_pkg::word_t pc,
    output logic            halt_taken
);

    import mips_pkg::*;

    word_t pend_target;  // jump target waiting for the delay slot.
    logic  pend_valid;
    word_t br_target;
    logic  taken;

    assign br_target  = pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
    assign taken      = ctrl.is_branch && ((rs_data == rt_data) != ctrl.branch_ne);
    assign halt_taken = retire && pend_valid && (pend_target == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= RESET_PC;
            pend_valid <= 1'b0;
        end else if (retire) begin
            pc         <= pend_valid ? pend_target : pc + 32'd4;  // slot done.
            pend_valid <= taken || ctrl.is_jr;
        end
    end

    always_ff @(posedge clk) begin
        if (retire && (taken || ctrl.is_jr)) begin
            pend_target <= ctrl.is_jr ? rs_data : br_target;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bus_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_master (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::bus_req_t req,
    output mips_pkg::word_t    address,
    output mips_pkg::word_t    writedata,
    output logic               read,
    output logic               write,
    input  logic               waitrequest,
    input  mips_pkg::word_t    readdata,
    output logic               done,
    output mips_pkg::word_t    rdata
);

    import mips_pkg::*;

    bus_req_t cur;  // request on the bus.
    logic     busy;

    assign busy      = cur.read || cur.write;
    assign address   = cur.addr;
    assign writedata = cur.wdata;
    assign read      = cur.read;
    assign write     = cur.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            cur.read  <= 1'b0;
            cur.write <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (req.read || req.write) cur <= req;
            end else if (!waitrequest) begin
                // transfer completes this cycle.
                cur.read  <= 1'b0;
                cur.write <= 1'b0;
                done      <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cur.read && !waitrequest) rdata <= readdata;
    end

endmodule

`default_nettype wire

// ==== verilog/mips_bus_cpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_bus_cpu #(
    parameter mips_pkg::word_t RESET_PC = mips_pkg::RESET_PC_DEFAULT
) (
    input  logic            clk,
    input  logic            rst,
    output logic            active,
    output mips_pkg::word_t register_v0,

    // avalon master.
    output mips_pkg::word_t address,
    output logic            read,
    output logic            write,
    output mips_pkg::word_t writedata,
    input  logic            waitrequest,
    input  mips_pkg::word_t readdata
);

    import mips_pkg::*;

    bus_req_t      bus_req;
    logic          bus_done;
    word_t         bus_rdata;
    instr_fields_t fields;
    ctrl_t         ctrl;
    logic          retire;
    logic          halt_taken;
    word_t         pc;
    word_t         rs_data;
    word_t         rt_data;
    word_t         alu_result;
    reg_addr_t     wr_addr;
    logic          wr_en;
    word_t         wr_data;

    // ############################
    // writeback path.
    assign wr_addr = ctrl.dest_is_rt ? fields.rt : fields.low.r.rd;
    assign wr_en   = retire && ctrl.reg_write;
    assign wr_data = ctrl.mem_to_reg ? bus_rdata : alu_result;

    cpu_control u_control (
        .clk        (clk),
        .rst        (rst),
        .bus_done   (bus_done),
        .bus_rdata  (bus_rdata),
        .halt_taken (halt_taken),
        .pc         (pc),
        .addr_src   (alu_result),
        .store_data (rt_data),
        .bus_req    (bus_req),
        .fields     (fields),
        .ctrl       (ctrl),
        .retire     (retire),
        .active     (active)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (fields.rs),
        .rt_addr (fields.rt),
        .wr_addr (wr_addr),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    alu u_alu (
        .fields  (fields),
        .ctrl    (ctrl),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .result  (alu_result)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clk        (clk),
        .rst        (rst),
        .retire     (retire),
        .ctrl       (ctrl),
        .imm        (fields.low.imm),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .pc         (pc),
        .halt_taken (halt_taken)
    );

    bus_master u_bus (
        .clk         (clk),
        .rst         (rst),
        .req         (bus_req),
        .address     (address),
        .writedata   (writedata),
        .read        (read),
        .write       (write),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .done        (bus_done),
        .rdata       (bus_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/avalon_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module avalon_ram (
    input  logic            clk,
    input  mips_pkg::word_t address,
    input  logic            read,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    output mips_pkg::word_t readdata,
    output logic            waitrequest,
    input  logic            stall,      // wait state for this cycle.
    input  logic            load_en,
    input  logic [7:0]      load_addr,
    input  mips_pkg::word_t load_data
);

    import mips_pkg::*;

    word_t      mem [0:255];
    logic [7:0] index;

    assign index       = address[9:2];  // byte address to word index.
    assign waitrequest = stall;
    assign readdata    = read ? mem[index] : '0;

    // load port wins over the bus.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (write && !waitrequest) begin
            mem[index] <= writedata;
        end
    end

endmodule

`default_nettype wire

// ==== tb/mips_bus_cpu_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_bus_cpu_properties (
    input logic            clk,
    input logic            rst,
    input logic            active,
    input mips_pkg::word_t address,
    input logic            read,
    input logic            write,
    input mips_pkg::word_t writedata,
    input logic            waitrequest
);

    // ############################
    // avalon master rules.
    no_read_write: assert property (@(posedge clk) disable iff (rst)
        !(read && write))
        else $error("read and write asserted together");

    hold_request: assert property (@(posedge clk) disable iff (rst)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(writedata) && $stable(read) && $stable(write))
        else $error("request changed while waitrequest was high");

    idle_after_reset: assert property (@(posedge clk)
        rst |=> !read && !write)
        else $error("bus request in the cycle after reset");

    // ############################
    // halt is sticky.
    active_no_rise: assert property (@(posedge clk)
        !active && !rst |=> !active)
        else $error("active rose without reset");

endmodule

bind mips_bus_cpu mips_bus_cpu_properties u_props (
    .clk         (clk),
    .rst         (rst),
    .active      (active),
    .address     (address),
    .read        (read),
    .write       (write),
    .writedata   (writedata),
    .waitrequest (waitrequest)
);

`default_nettype wire

// ==== tb/mips_bus_cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_bus_cpu_tb;

    import mips_pkg::*;

    localparam int    CLK_PERIOD   = 100;
    localparam int    DRIVE_DELAY  = 1;
    localparam int    RESET_CYCLES = 10;
    localparam int    MAX_WAIT     = 3;   // longest run of wait states.
    localparam int    MAX_INSTR    = 64;  // instruction budget per test.
    localparam int    CHAIN_LEN    = 20;
    localparam int    N_TESTS      = 6;
    localparam int    INSTR_CYCLES = 4 + 2 * (MAX_WAIT + 3);
    localparam int    TEST_CYCLES  = 256 + RESET_CYCLES + 20 + MAX_INSTR * INSTR_CYCLES;
    localparam int    WATCH_CYCLES = N_TESTS * TEST_CYCLES;
    localparam word_t RESET_PC     = 32'h0000_0004;
    localparam logic [31:0] SEED   = 32'h113d_fe53;

    // ############################
    // mips encodings.
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2b;
    localparam logic [5:0] FUN_JR    = 6'h08;
    localparam logic [5:0] FUN_ADDU  = 6'h21;
    localparam logic [5:0] FUN_SUBU  = 6'h23;
    localparam logic [5:0] FUN_AND   = 6'h24;
    localparam logic [5:0] FUN_OR    = 6'h25;
    localparam logic [5:0] FUN_SLT   = 6'h2a;
    localparam logic [4:0] R0 = 5'd0;
    localparam logic [4:0] V0 = 5'd2;
    localparam logic [4:0] V1 = 5'd3;
    localparam logic [4:0] T0 = 5'd8;
    localparam logic [4:0] T1 = 5'd9;

    logic       clk;
    logic       rst;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       read;
    logic       write;
    word_t      writedata;
    logic       waitrequest;
    word_t      readdata;
    logic       stall;
    logic       load_en;
    logic [7:0] load_addr;
    word_t      load_data;

    word_t       image [0:255];    // program loaded for the next test.
    word_t       ref_mem [0:255];  // memory after the reference run.
    logic [31:0] lfsr;
    logic        waits_on;
    int          stall_run;
    int          prog_pos;
    int          errors;
    int          checks;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    mips_bus_cpu #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    avalon_ram ram (
        .clk         (clk),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .stall       (stall),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic word_t take_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    function automatic word_t rtype(input logic [5:0] funct, input logic [4:0] rd, rs, rt);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t itype(input logic [5:0] op, input logic [4:0] rt, rs,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // ############################
    // instruction-set model with one delay slot.
    function automatic word_t run_reference();
        word_t regs [0:31];
        word_t pc;
        word_t npc;
        word_t nnpc;
        word_t ir;
        word_t a;
        word_t b;
        word_t imm_ext;
        word_t addr;
        int    steps;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = image[i];
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc    = RESET_PC;
        npc   = RESET_PC + 32'd4;
        steps = 0;
        while (pc != '0 && steps < MAX_INSTR) begin  // jr to zero ends after its slot.
            ir      = ref_mem[pc[9:2]];
            a       = regs[ir[25:21]];
            b       = regs[ir[20:16]];
            imm_ext = {{16{ir[15]}}, ir[15:0]};
            addr    = a + imm_ext;
            nnpc    = npc + 32'd4;
            case (ir[31:26])
                6'h00: begin
                    case (ir[5:0])
                        FUN_ADDU: regs[ir[15:11]] = a + b;
                        FUN_SUBU: regs[ir[15:11]] = a - b;
                        FUN_AND:  regs[ir[15:11]] = a & b;
                        FUN_OR:   regs[ir[15:11]] = a | b;
                        FUN_SLT:  regs[ir[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FUN_JR:   nnpc = a;
                        default: ;
                    endcase
                end
                OPC_ADDIU: regs[ir[20:16]] = addr;
                OPC_LW:    regs[ir[20:16]] = ref_mem[addr[9:2]];
                OPC_SW:    ref_mem[addr[9:2]] = b;
                OPC_BEQ:   if (a == b) nnpc = npc + (imm_ext << 2);
                OPC_BNE:   if (a != b) nnpc = npc + (imm_ext << 2);
                default: ;
            endcase
            regs[0] = '0;
            pc      = npc;
            npc     = nnpc;
            steps++;
        end
        return regs[2];
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "pass" : "FAIL",
                 test_errors);
        test_errors = 0;
    endtask

    // ############################
    // program images.
    task automatic clear_image();
        for (int i = 0; i < 256; i++) begin
            image[i] = {8'(i) ^ 8'h5a, 16'hc0de, 8'(i)};
        end
        prog_pos = 1;  // word at RESET_PC.
    endtask

    task automatic emit(input word_t w);
        image[prog_pos] = w;
        prog_pos++;
    endtask

    task automatic build_reference_program();
        clear_image();
        emit(itype(OPC_ADDIU, V0, R0, 16'h0010));
        emit(itype(OPC_ADDIU, V1, R0, 16'h0020));
        emit(itype(OPC_BNE, V1, V0, 16'd2));       // taken.
        emit(itype(OPC_ADDIU, V0, V0, 16'h0040));  // delay slot.
        emit(itype(OPC_ADDIU, V0, V0, 16'h0100));  // skipped.
        emit(rtype(FUN_ADDU, V0, V0, V1));
        emit(rtype(FUN_JR, R0, R0, R0));
        emit(rtype(FUN_ADDU, V0, V0, V0));
    endtask

    task automatic build_random_chain();
        word_t     sel;
        reg_addr_t d;
        reg_addr_t s;
        reg_addr_t t;
        clear_image();
        for (int r = 1; r < 8; r++) begin
            emit(itype(OPC_ADDIU, 5'(r), R0, 16'(take_bits(16))));
        end
        for (int k = 0; k < CHAIN_LEN; k++) begin
            sel = take_bits(3) % 32'd6;
            d   = reg_addr_t'(take_bits(3));
            s   = reg_addr_t'(take_bits(3));
            t   = reg_addr_t'(take_bits(3));
            case (sel)
                0: emit(itype(OPC_ADDIU, d, s, 16'(take_bits(16))));
                1: emit(rtype(FUN_ADDU, d, s, t));
                2: emit(rtype(FUN_SUBU, d, s, t));
                3: emit(rtype(FUN_AND, d, s, t));
                4: emit(rtype(FUN_OR, d, s, t));
                default: emit(rtype(FUN_SLT, d, s, t));
            endcase
        end
        emit(rtype(FUN_JR, R0, R0, R0));
        emit(32'h0000_0000);
    endtask

    task automatic build_memory_program();
        clear_image();
        emit(itype(OPC_ADDIU, T0, R0, 16'h0200));  // data area at word 128.
        emit(itype(OPC_ADDIU, T1, R0, 16'h1234));
        emit(itype(OPC_SW, T1, T0, 16'd4));
        emit(itype(OPC_ADDIU, R0, R0, 16'h0055));  // r0 keeps zero.
        emit(itype(OPC_SW, R0, T0, 16'd8));
        emit(itype(OPC_LW, V0, T0, 16'd4));
        emit(itype(OPC_LW, V1, T0, 16'd12));      // untouched fill word.
        emit(rtype(FUN_ADDU, V0, V0, V1));
        emit(rtype(FUN_JR, R0, R0, R0));
        emit(itype(OPC_SW, V0, T0, 16'd16));       // store in the delay slot.
    endtask

    task automatic build_branch_program();
        clear_image();
        emit(itype(OPC_ADDIU, V0, R0, 16'd1));
        emit(itype(OPC_ADDIU, V1, R0, 16'd5));
        emit(itype(OPC_BEQ, V1, V0, 16'd2));       // not taken.
        emit(itype(OPC_ADDIU, V0, V0, 16'd2));
        emit(itype(OPC_ADDIU, V0, V0, 16'd4));
        emit(itype(OPC_BNE, V1, V0, 16'd2));       // taken.
        emit(itype(OPC_ADDIU, V0, V0, 16'd8));
        emit(itype(OPC_ADDIU, V0, V0, 16'h0100));
        emit(itype(OPC_ADDIU, V1, R0, 16'd15));
        emit(itype(OPC_BEQ, V1, V0, 16'd2));       // taken.
        emit(itype(OPC_ADDIU, V0, V0, 16'd16));
        emit(itype(OPC_ADDIU, V0, V0, 16'h0200));
        emit(itype(OPC_BNE, V0, V0, 16'd2));       // not taken.
        emit(rtype(FUN_SUBU, V0, V0, V1));
        emit(rtype(FUN_JR, R0, R0, R0));
        emit(rtype(FUN_OR, V0, V0, V1));
    endtask

    // load memory under reset, then release and wait for the halt.
    task automatic run_program();
        @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;
        for (int i = 0; i < 256; i++) begin
            load_en   = 1'b1;
            load_addr = 8'(i);
            load_data = image[i];
            @(posedge clk);
            #DRIVE_DELAY;
        end
        load_en = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(negedge clk);
        check("active", {31'd0, active}, 32'd1);
        while (active) begin
            @(negedge clk);
        end
    endtask

    // random wait states, never more than MAX_WAIT in a row.
    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (waits_on && stall_run < MAX_WAIT && take_bits(1) == 32'd1) begin
            stall     = 1'b1;
            stall_run = stall_run + 1;
        end else begin
            stall     = 1'b0;
            stall_run = 0;
        end
    end

    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the DUT did not halt in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        word_t exp_v0;
        clk          = 1'b0;
        rst          = 1'b1;
        stall        = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        waits_on     = 1'b0;
        stall_run    = 0;
        lfsr         = SEED;
        errors       = 0;
        checks       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;

        build_reference_program();
        run_program();
        exp_v0 = run_reference();
        check("reference v0", exp_v0, 32'h0000_00e0);
        check("register_v0", register_v0, exp_v0);
        finish_test("1 reference program");

        build_random_chain();
        run_program();
        exp_v0 = run_reference();
        check("register_v0", register_v0, exp_v0);
        finish_test("2 random alu chain");

        waits_on = 1'b1;  // same image as test 2.
        run_program();
        waits_on = 1'b0;
        check("register_v0", register_v0, run_reference());
        finish_test("5 random alu chain with wait states");

        build_memory_program();
        run_program();
        exp_v0 = run_reference();
        check("register_v0", register_v0, exp_v0);
        for (int i = 0; i < 256; i++) begin
            check($sformatf("mem[%0d]", i), ram.mem[i], ref_mem[i]);
        end
        finish_test("3 store and load");

        build_branch_program();
        run_program();
        exp_v0 = run_reference();
        check("register_v0", register_v0, exp_v0);
        finish_test("4 branches and delay slots");

        repeat (20) begin
            @(negedge clk);
            check("active", {31'd0, active}, 32'd0);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(negedge clk);
        check("active", {31'd0, active}, 32'd1);
        finish_test("6 halt holds until reset");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_bus_cpu.f ====
verilog/mips_pkg.sv
verilog/cpu_control.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/pc_unit.sv
verilog/bus_master.sv
verilog/mips_bus_cpu.sv
tb/avalon_ram.sv
tb/mips_bus_cpu_properties.sv
tb/mips_bus_cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mips_bus_cpu testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mips_bus_cpu_tb -f mips_bus_cpu.f -o mips_bus_cpu_sim

./obj_dir/mips_bus_cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
